/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module tb_top -f flist.f
	@out="$$(./obj_dir/Vtb_top)"; echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

/* flist.f */
+incdir+src
src/glue_pkg.sv
src/io_reg_if.sv
src/io_port_decoder.sv
src/ems_page_mapper.sv
src/lpt_port.sv
src/bus_read_mux.sv
src/xt_io_glue.sv
test/tb_checker.sv
test/tb_top.sv

/* src/bus_read_mux.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Read-back mux
// Registers the selected block's data onto the
// CPU data bus with a from-chipset flag
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module bus_read_mux
    import glue_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   rd_strobe_i,
    io_reg_if.host ems_bus,
    io_reg_if.host lpt_bus,
    output data_t  data_bus_o,
    output logic   from_chipset_o
);

    logic ems_read;
    logic lpt_read;

    assign ems_read = rd_strobe_i & ems_bus.sel;
    assign lpt_read = rd_strobe_i & lpt_bus.sel;

    // EMS first, then LPT
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            from_chipset_o <= 1'b0;
            data_bus_o     <= '0;
        end
        else if (ems_read) begin
            from_chipset_o <= 1'b1;
            data_bus_o     <= ems_bus.rdata;
        end
        else if (lpt_read) begin
            from_chipset_o <= 1'b1;
            data_bus_o     <= lpt_bus.rdata;
        end
        else begin
            from_chipset_o <= 1'b0;
            data_bus_o     <= '0;
        end
    end

endmodule

/* src/ems_page_mapper.sv */
// ~~~~~~~~~~~~~~~~~~~~
// EMS page mapper
// Four page registers at 260h..263h and the
// memory window decode against the page frame
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "glue_defines.svh"

module ems_page_mapper
    import glue_pkg::*;
(
    input  logic                               clock,
    input  logic                               reset,
    io_reg_if.device                           bus,
    input  mem_addr_t                          mem_address_i,
    input  logic                               io_active_i,
    input  ems_frame_sel_t                     ems_frame_i,
    output logic      [`GLUE_EMS_SLOTS-1:0]    ems_hit_o,
    output ems_page_t [`GLUE_EMS_SLOTS-1:0]    ems_page_o
);

    // Frame nibble plus slot index
    localparam int WIN_BITS = 4 + $bits(ems_slot_t);

    ems_entry_t entry_q [`GLUE_EMS_SLOTS];

    logic       wr_take;
    ems_entry_t wr_entry;

    logic       pipe_valid;
    ems_slot_t  pipe_slot;
    ems_entry_t pipe_entry;

    logic [3:0] frame_nibble;

    // New entry from the written byte with codes 80h..FEh ignored
    always_comb begin
        wr_entry = '0;
        wr_take  = 1'b0;
        if (bus.wdata == `GLUE_EMS_DISABLE_CODE) begin
            wr_entry.en   = 1'b0;
            wr_entry.page = '1;
            wr_take       = bus.sel & bus.wr;
        end
        else if (bus.wdata < `GLUE_EMS_MAP_LIMIT) begin
            wr_entry.en   = 1'b1;
            wr_entry.page = bus.wdata[6:0];
            wr_take       = bus.sel & bus.wr;
        end
    end

    // Stage 1 of the write
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            pipe_valid <= 1'b0;
        end
        else begin
            pipe_valid <= wr_take;
        end
    end

    always_ff @(posedge clock) begin
        pipe_slot  <= ems_slot_t'(bus.offset);
        pipe_entry <= wr_entry;
    end

    // Stage 2 updates the page register
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `GLUE_EMS_SLOTS; i++) begin
                entry_q[i] <= '0;
            end
        end
        else if (pipe_valid) begin
            entry_q[pipe_slot] <= pipe_entry;
        end
    end

    assign bus.rdata = entry_q[bus.offset].en ? data_t'(entry_q[bus.offset].page)
                                              : data_t'(`GLUE_EMS_DISABLE_CODE);

    always_comb begin
        case (ems_frame_i)
            2'd0:    frame_nibble = `GLUE_EMS_FRAME_A;
            2'd1:    frame_nibble = `GLUE_EMS_FRAME_C;
            default: frame_nibble = `GLUE_EMS_FRAME_D;
        endcase
    end

    // Each slot owns a 16 KB window inside the frame
    always_comb begin
        for (int i = 0; i < `GLUE_EMS_SLOTS; i++) begin
            ems_hit_o[i]  = ~io_active_i & entry_q[i].en
                          & (mem_address_i[`GLUE_MEM_ADDR_W-1 -: WIN_BITS]
                             == {frame_nibble, ems_slot_t'(i)});
            ems_page_o[i] = entry_q[i].page;
        end
    end

endmodule

/* src/glue_defines.svh */
// ~~~~~~~~~~~~~~~~~~~~
// XT I/O glue constants
// Port bases, EMS page frames and bus widths
// ~~~~~~~~~~~~~~~~~~~~

`ifndef GLUE_DEFINES_SVH
`define GLUE_DEFINES_SVH

// Bus widths
`define GLUE_DATA_W             8
`define GLUE_MEM_ADDR_W         20
`define GLUE_IO_ADDR_W          16

// EMS page mapper
`define GLUE_EMS_SLOTS          4
`define GLUE_EMS_PORT_BASE      16'h0260
`define GLUE_EMS_FRAME_A        4'hA
`define GLUE_EMS_FRAME_C        4'hC
`define GLUE_EMS_FRAME_D        4'hD
`define GLUE_EMS_DISABLE_CODE   8'hFF
`define GLUE_EMS_MAP_LIMIT      8'h80

// Parallel port
`define GLUE_LPT_DATA_PORT      16'h0378
`define GLUE_LPT_STATUS_PORT    16'h0379
`define GLUE_LPT_FULL_BIT       6

`endif

/* src/glue_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// XT I/O glue types
// Bus words and EMS mapping entries
// ~~~~~~~~~~~~~~~~~~~~

`include "glue_defines.svh"

package glue_pkg;

    typedef logic [`GLUE_DATA_W-1:0]     data_t;
    typedef logic [`GLUE_MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [`GLUE_IO_ADDR_W-1:0]  io_addr_t;

    // 16 KB page number within expanded memory
    typedef logic [6:0] ems_page_t;

    typedef logic [$clog2(`GLUE_EMS_SLOTS)-1:0] ems_slot_t;

    // 0 selects A000h, 1 selects C000h, anything else D000h
    typedef logic [1:0] ems_frame_sel_t;

    typedef struct packed {
        logic      en;
        ems_page_t page;
    } ems_entry_t;

endpackage

/* src/io_port_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~
// I/O port decoder
// Turns bus strobes and port addresses into
// per-block register accesses
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "glue_defines.svh"

module io_port_decoder
    import glue_pkg::*;
(
    input  logic     io_read_n_i,
    input  logic     io_write_n_i,
    input  logic     address_enable_n_i,
    input  io_addr_t address_i,
    input  data_t    data_i,
    input  logic     ems_enabled_i,
    io_reg_if.host   ems_bus,
    io_reg_if.host   lpt_bus,
    output logic     rd_strobe_o
);

    localparam io_addr_t EMS_BASE    = `GLUE_EMS_PORT_BASE;
    localparam io_addr_t LPT_DATA    = `GLUE_LPT_DATA_PORT;
    localparam io_addr_t LPT_STATUS  = `GLUE_LPT_STATUS_PORT;
    // Origin for LPT offsets so data lands at 1 and status at 2
    localparam io_addr_t LPT_ORIGIN  = LPT_DATA - io_addr_t'(1);

    logic     io_cycle;
    logic     ems_hit;
    logic     lpt_hit;
    io_addr_t lpt_rel;

    // Any I/O strobe with AEN low
    assign io_cycle = (~io_read_n_i | ~io_write_n_i) & ~address_enable_n_i;

    // 260h..263h while EMS is switched on
    assign ems_hit = io_cycle & ems_enabled_i
                   & (address_i[`GLUE_IO_ADDR_W-1:2] == EMS_BASE[`GLUE_IO_ADDR_W-1:2]);

    // Full compare on both LPT ports
    assign lpt_hit = io_cycle & ((address_i == LPT_DATA) | (address_i == LPT_STATUS));

    assign lpt_rel = address_i - LPT_ORIGIN;

    assign ems_bus.sel    = ems_hit;
    assign ems_bus.wr     = ~io_write_n_i;
    assign ems_bus.offset = address_i[1:0];
    assign ems_bus.wdata  = data_i;

    assign lpt_bus.sel    = lpt_hit;
    assign lpt_bus.wr     = ~io_write_n_i;
    assign lpt_bus.offset = lpt_rel[1:0];
    assign lpt_bus.wdata  = data_i;

    assign rd_strobe_o = ~io_read_n_i;

endmodule

/* src/io_reg_if.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Register access link
// Carries decoded I/O cycles to one register block
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "glue_defines.svh"

interface io_reg_if;

    logic                    sel;
    logic                    wr;
    logic [1:0]              offset;
    logic [`GLUE_DATA_W-1:0] wdata;
    logic [`GLUE_DATA_W-1:0] rdata;

    modport host (
        output sel, wr, offset, wdata,
        input  rdata
    );

    modport device (
        input  sel, wr, offset, wdata,
        output rdata
    );

endinterface

/* src/lpt_port.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Parallel port
// Data latch at 378h, status byte at 379h
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "glue_defines.svh"

module lpt_port
    import glue_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    io_reg_if.device bus,
    input  logic     dss_full_i
);

    localparam logic [1:0] DATA_OFS   = 2'd1;
    localparam logic [1:0] STATUS_OFS = 2'd2;

    data_t data_q;
    data_t status;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_q <= '1;
        end
        else if (bus.sel && bus.wr && (bus.offset == DATA_OFS)) begin
            data_q <= bus.wdata;
        end
    end

    // Sound FIFO full flag only
    assign status = data_t'(dss_full_i) << `GLUE_LPT_FULL_BIT;

    always_comb begin
        case (bus.offset)
            DATA_OFS:   bus.rdata = data_q;
            STATUS_OFS: bus.rdata = status;
            default:    bus.rdata = '0;
        endcase
    end

endmodule

/* src/xt_io_glue.sv */
// ~~~~~~~~~~~~~~~~~~~~
// XT I/O glue top
// EMS mapper, LPT port and CPU read-back
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "glue_defines.svh"

module xt_io_glue
    import glue_pkg::*;
(
    input  logic                                          clock,
    input  logic                                          reset,
    input  mem_addr_t                                     address_i,
    input  data_t                                         data_i,
    input  logic                                          io_read_n_i,
    input  logic                                          io_write_n_i,
    input  logic                                          address_enable_n_i,
    input  logic                                          ems_enabled_i,
    input  ems_frame_sel_t                                ems_frame_i,
    input  logic                                          dss_full_i,
    output data_t                                         data_bus_o,
    output logic                                          from_chipset_o,
    output logic [`GLUE_EMS_SLOTS-1:0]                    ems_hit_o,
    output logic [`GLUE_EMS_SLOTS*$bits(ems_page_t)-1:0]  ems_page_o
);

    io_reg_if ems_reg ();
    io_reg_if lpt_reg ();

    logic rd_strobe;

    // Windows stay quiet during any I/O cycle
    wire io_active = ~io_read_n_i | ~io_write_n_i;

    io_port_decoder u_decoder (
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .address_enable_n_i (address_enable_n_i),
        .address_i          (address_i[`GLUE_IO_ADDR_W-1:0]),
        .data_i             (data_i),
        .ems_enabled_i      (ems_enabled_i),
        .ems_bus            (ems_reg.host),
        .lpt_bus            (lpt_reg.host),
        .rd_strobe_o        (rd_strobe)
    );

    ems_page_mapper u_ems (
        .clock              (clock),
        .reset              (reset),
        .bus                (ems_reg.device),
        .mem_address_i      (address_i),
        .io_active_i        (io_active),
        .ems_frame_i        (ems_frame_i),
        .ems_hit_o          (ems_hit_o),
        .ems_page_o         (ems_page_o)
    );

    lpt_port u_lpt (
        .clock              (clock),
        .reset              (reset),
        .bus                (lpt_reg.device),
        .dss_full_i         (dss_full_i)
    );

    bus_read_mux u_read_mux (
        .clock              (clock),
        .reset              (reset),
        .rd_strobe_i        (rd_strobe),
        .ems_bus            (ems_reg.host),
        .lpt_bus            (lpt_reg.host),
        .data_bus_o         (data_bus_o),
        .from_chipset_o     (from_chipset_o)
    );

endmodule

/* test/tb_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~
// XT I/O glue checker
// Compares DUT outputs with the expected values
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_checker (
    input logic [7:0]  data_bus_i,
    input logic        from_chipset_i,
    input logic [3:0]  ems_hit_i,
    input logic [27:0] ems_page_i
);

    int test_checks  = 0;
    int test_errors  = 0;
    int total_checks = 0;
    int total_errors = 0;
    int test_count   = 0;

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s: expected %h actual %h", tb_top.test_name, what,
                     expected, actual);
            test_errors  = test_errors + 1;
            total_errors = total_errors + 1;
        end
    endtask

    always @(tb_top.check_ev) begin
        test_checks  = test_checks + 1;
        total_checks = total_checks + 1;
        if (tb_top.check_kind == tb_top.KIND_READ) begin
            compare_value("data_bus_o", 32'(tb_top.exp_data), 32'(data_bus_i));
            compare_value("from_chipset_o", 32'(tb_top.exp_flag), 32'(from_chipset_i));
        end
        else begin
            compare_value("ems_hit_o", 32'(tb_top.exp_hit), 32'(ems_hit_i));
            compare_value("ems_page_o", 32'(tb_top.exp_pages), 32'(ems_page_i));
        end
    end

    // One line per finished test
    always @(tb_top.test_done_ev) begin
        test_count = test_count + 1;
        if (test_errors == 0) begin
            $display("test %s: ok, %0d checks", tb_top.test_name, test_checks);
        end
        else begin
            $display("test %s: failed, %0d errors in %0d checks", tb_top.test_name,
                     test_errors, test_checks);
        end
        test_checks = 0;
        test_errors = 0;
    end

endmodule

/* test/tb_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// XT I/O glue testbench
// Drives I/O and memory cycles, models EMS and LPT
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_top;

    localparam int          RESET_CYCLES = 5;
    localparam int unsigned RANDOM_SEED  = 32'hcdf6_513b;
    localparam int          N_EMS_ROUNDS = 8;
    localparam int          N_WIN        = 16;
    localparam int          N_LPT        = 8;
    localparam int TOTAL_ACCESSES = 3 + N_EMS_ROUNDS * 8 + 4 + 4 * (N_WIN + 1) + 4 * 3
                                  + N_LPT * 2 + 2 + 1;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 5 * TOTAL_ACCESSES + 200;
    localparam logic [19:0] EMS_PORT = 20'h00260;
    localparam logic [19:0] LPT_DATA = 20'h00378;
    localparam logic [19:0] LPT_STAT = 20'h00379;
    localparam logic KIND_READ   = 1'b0;
    localparam logic KIND_WINDOW = 1'b1;

    logic        clock = 1'b0;
    logic        reset = 1'b1;
    logic [19:0] address_i = '0;
    logic [7:0]  data_i = '0;
    logic        io_read_n_i = 1'b1;
    logic        io_write_n_i = 1'b1;
    logic        address_enable_n_i = 1'b0;
    logic        ems_enabled_i = 1'b1;
    logic [1:0]  ems_frame_i = '0;
    logic        dss_full_i = 1'b0;
    logic [7:0]  data_bus_o;
    logic        from_chipset_o;
    logic [3:0]  ems_hit_o;
    logic [27:0] ems_page_o;

    // Expected values handed to the checker with each check_ev
    event        check_ev;
    event        test_done_ev;
    string       test_name = "none";
    logic        check_kind;
    logic [7:0]  exp_data;
    logic        exp_flag;
    logic [3:0]  exp_hit;
    logic [27:0] exp_pages;

    logic        model_en [4];
    logic [6:0]  model_page [4];
    int          cycle_count = 0;

    xt_io_glue dut_i (
        .clock(clock), .reset(reset), .address_i(address_i), .data_i(data_i),
        .io_read_n_i(io_read_n_i), .io_write_n_i(io_write_n_i),
        .address_enable_n_i(address_enable_n_i), .ems_enabled_i(ems_enabled_i),
        .ems_frame_i(ems_frame_i), .dss_full_i(dss_full_i), .data_bus_o(data_bus_o),
        .from_chipset_o(from_chipset_o), .ems_hit_o(ems_hit_o), .ems_page_o(ems_page_o)
    );

    tb_checker u_checker (
        .data_bus_i(data_bus_o), .from_chipset_i(from_chipset_o),
        .ems_hit_i(ems_hit_o), .ems_page_i(ems_page_o)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic void ems_write_model(input logic [1:0] slot, input logic [7:0] value);
        if (value == 8'hFF) begin
            model_en[slot]   = 1'b0;
            model_page[slot] = 7'h7F;
        end
        else if (value < 8'h80) begin
            model_en[slot]   = 1'b1;
            model_page[slot] = value[6:0];
        end
    endfunction

    function automatic logic [7:0] ems_read_model(input logic [1:0] slot);
        return model_en[slot] ? {1'b0, model_page[slot]} : 8'hFF;
    endfunction

    function automatic logic [3:0] frame_nibble(input logic [1:0] frame);
        case (frame)
            2'd0:    return 4'hA;
            2'd1:    return 4'hC;
            default: return 4'hD;
        endcase
    endfunction

    function automatic logic [3:0] ems_hit_model(input logic [19:0] addr, input logic io_active,
                                                 input logic [1:0] frame);
        logic [3:0] hits;
        for (int i = 0; i < 4; i++) begin
            hits[i] = !io_active && model_en[i]
                    && (addr[19:14] == {frame_nibble(frame), 2'(i)});
        end
        return hits;
    endfunction

    function automatic logic [7:0] lpt_status_model(input logic full);
        return {1'b0, full, 6'b0};
    endfunction

    task automatic bus_idle();
        @(posedge clock);
        io_read_n_i        <= 1'b1;
        io_write_n_i       <= 1'b1;
        address_enable_n_i <= 1'b0;
    endtask

    task automatic io_write(input logic [19:0] addr, input logic [7:0] value);
        @(posedge clock);
        address_i          <= addr;
        data_i             <= value;
        io_read_n_i        <= 1'b1;
        io_write_n_i       <= 1'b0;
        address_enable_n_i <= 1'b0;
    endtask

    task automatic expect_read(input logic [7:0] value, input logic flag);
        exp_data   = value;
        exp_flag   = flag;
        check_kind = KIND_READ;
        -> check_ev;
    endtask

    // Read is sampled on the edge after it is driven and data follows that edge
    task automatic io_read_check(input logic [19:0] addr, input logic [7:0] value,
                                 input logic flag);
        @(posedge clock);
        address_i          <= addr;
        io_read_n_i        <= 1'b0;
        io_write_n_i       <= 1'b1;
        address_enable_n_i <= 1'b0;
        @(posedge clock);
        io_read_n_i <= 1'b1;
        @(negedge clock);
        expect_read(value, flag);
    endtask

    // AEN stays high with a strobe so nothing decodes as I/O
    task automatic window_check(input logic [19:0] addr, input logic strobe,
                                input logic [1:0] frame);
        @(posedge clock);
        address_i          <= addr;
        ems_frame_i        <= frame;
        io_read_n_i        <= ~strobe;
        address_enable_n_i <= strobe;
        @(negedge clock);
        exp_hit    = ems_hit_model(addr, strobe, frame);
        exp_pages  = {model_page[3], model_page[2], model_page[1], model_page[0]};
        check_kind = KIND_WINDOW;
        -> check_ev;
    endtask

    task automatic end_test();
        -> test_done_ev;
        bus_idle();
    endtask

    function automatic logic [7:0] random_ems_byte();
        case ($urandom_range(0, 2))
            0:       return 8'($urandom_range(0, 127));
            1:       return 8'hFF;
            default: return 8'($urandom_range(128, 254));
        endcase
    endfunction

    initial begin
        logic [1:0]  slot;
        logic [7:0]  value;
        logic [19:0] addr;
        void'($urandom(RANDOM_SEED));
        for (int i = 0; i < 4; i++) begin
            model_en[i]   = 1'b0;
            model_page[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        test_name = "reset";
        window_check(20'hA0000, 1'b0, 2'd0);
        bus_idle();
        @(negedge clock);
        expect_read(8'h00, 1'b0);
        io_read_check(LPT_DATA, 8'hFF, 1'b1);
        end_test();

        test_name = "ems_write_read";
        for (int r = 0; r < N_EMS_ROUNDS; r++) begin
            for (int w = 0; w < 4; w++) begin
                slot  = 2'($urandom_range(0, 3));
                value = random_ems_byte();
                io_write(EMS_PORT + 20'(slot), value);
                ems_write_model(slot, value);
            end
            bus_idle();
            for (int s = 0; s < 4; s++) begin
                io_read_check(EMS_PORT + 20'(s), ems_read_model(2'(s)), 1'b1);
            end
        end
        end_test();

        test_name = "ems_windows";
        for (int s = 0; s < 4; s++) begin
            value = 8'($urandom_range(0, 127));
            io_write(EMS_PORT + 20'(s), value);
            ems_write_model(2'(s), value);
        end
        bus_idle();
        bus_idle();
        for (int f = 0; f < 4; f++) begin
            for (int n = 0; n < N_WIN; n++) begin
                addr = 20'($urandom);
                if ($urandom_range(0, 1) == 1) begin
                    addr[19:16] = frame_nibble(2'(f));
                end
                window_check(addr, 1'b0, 2'(f));
            end
            window_check({frame_nibble(2'(f)), 16'h4000}, 1'b1, 2'(f));
        end
        end_test();

        test_name = "ems_disabled";
        @(posedge clock);
        ems_enabled_i <= 1'b0;
        for (int s = 0; s < 4; s++) begin
            io_write(EMS_PORT + 20'(s), 8'($urandom_range(0, 127)));
        end
        bus_idle();
        for (int s = 0; s < 4; s++) begin
            io_read_check(EMS_PORT + 20'(s), 8'h00, 1'b0);
        end
        @(posedge clock);
        ems_enabled_i <= 1'b1;
        for (int s = 0; s < 4; s++) begin
            io_read_check(EMS_PORT + 20'(s), ems_read_model(2'(s)), 1'b1);
        end
        end_test();

        test_name = "lpt";
        for (int n = 0; n < N_LPT; n++) begin
            value = 8'($urandom);
            io_write(LPT_DATA, value);
            io_read_check(LPT_DATA, value, 1'b1);
        end
        @(posedge clock);
        dss_full_i <= 1'b0;
        io_read_check(LPT_STAT, lpt_status_model(1'b0), 1'b1);
        @(posedge clock);
        dss_full_i <= 1'b1;
        io_read_check(LPT_STAT, lpt_status_model(1'b1), 1'b1);
        end_test();

        test_name = "unmapped";
        io_read_check(20'h003F8, 8'h00, 1'b0);
        end_test();

        @(posedge clock);
        $display("%0d tests, %0d checks, %0d errors", u_checker.test_count,
                 u_checker.total_checks, u_checker.total_errors);
        if (u_checker.total_errors == 0) begin
            $display("PASS: all tests");
        end
        else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
